// File: src/spi_reg_pkg.sv
package spi_reg_pkg;

  typedef logic [2:0] reg_addr_t;

  localparam reg_addr_t ADDR_CR1 = 3'd0;
  localparam reg_addr_t ADDR_CR2 = 3'd1;
  localparam reg_addr_t ADDR_BR  = 3'd2;
  localparam reg_addr_t ADDR_SR  = 3'd3;
  localparam reg_addr_t ADDR_DR  = 3'd5;

  localparam logic [7:0] CR1_RESET = 8'h04;
  localparam logic [7:0] CR2_RESET = 8'h00;
  localparam logic [7:0] BR_RESET  = 8'h00;
  localparam logic [7:0] CR2_MASK  = 8'h1B;
  localparam logic [7:0] BR_MASK   = 8'h77;

  localparam int CR1_SPIE  = 7;
  localparam int CR1_SPE   = 6;
  localparam int CR1_SPTIE = 5;
  localparam int CR1_MSTR  = 4;
  localparam int CR1_CPOL  = 3;
  localparam int CR1_CPHA  = 2;
  localparam int CR1_SSOE  = 1;
  localparam int CR1_LSBFE = 0;

  localparam int CR2_MODFEN  = 4;
  localparam int CR2_SPISWAI = 1;

  // BR holds sppr in the upper nibble and spr in the lower one
  localparam int BR_SPPR_LSB = 4;
  localparam int BR_SPR_LSB  = 0;

  localparam int SR_SPIF  = 7;
  localparam int SR_SPTEF = 5;
  localparam int SR_MODF  = 4;

  typedef enum logic [1:0] {IDLE, SETUP, ENABLE} apb_state_e;

endpackage

// File: src/spi_xfer_pkg.sv
package spi_xfer_pkg;

  typedef logic [7:0] spi_byte_t;
  typedef logic [2:0] spi_div_t;

  // wide enough for (7+1) << 7
  typedef logic [10:0] spi_count_t;

  // sck edges in one byte
  typedef logic [3:0] spi_edge_t;
  localparam spi_edge_t LAST_EDGE = 4'd15;

  typedef enum logic [1:0] {SPI_RUN, SPI_WAIT, SPI_STOP} spi_mode_e;

  typedef struct packed {
    logic     cpol;
    logic     cpha;
    logic     lsbfe;
    logic     ssoe;
    spi_div_t sppr;
    spi_div_t spr;
  } spi_cfg_t;

  typedef struct packed {
    logic      tip;
    logic      done;
    spi_byte_t rx_data;
  } spi_status_t;

endpackage

// File: src/spi_apb_regs.sv
`timescale 1ns/1ns

module spi_apb_regs
  import spi_reg_pkg::*;
  import spi_xfer_pkg::*;
(
  input  logic        PClk,
  input  logic        PRESETn,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  reg_addr_t   paddr,
  input  spi_byte_t   pwdata,
  output spi_byte_t   prdata,
  output logic        pready,
  output logic        pslverr,
  input  logic        ss_in,
  input  spi_status_t status,
  output spi_cfg_t    cfg,
  output logic        start,
  output spi_byte_t   tx_data,
  output logic        baud_run,
  output spi_mode_e   mode,
  output logic        irq
);

  apb_state_e state;
  apb_state_e state_nxt;
  spi_mode_e  mode_nxt;
  spi_byte_t  cr1;
  spi_byte_t  cr2;
  spi_byte_t  br;
  spi_byte_t  dr;
  spi_byte_t  sr;
  logic       access;
  logic       wr_en;
  logic       rd_en;
  logic       dr_wr;
  logic       spif;
  logic       sptef;
  logic       modf;

  // state holds the phase of the previous cycle
  always_ff @(posedge PClk) begin
    if (!PRESETn) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    case (state)
      IDLE:    state_nxt = (psel && !penable) ? SETUP : IDLE;
      SETUP:   state_nxt = (psel && penable) ? ENABLE : (psel ? SETUP : IDLE);
      ENABLE:  state_nxt = (psel && !penable) ? SETUP : IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  assign access  = (state == SETUP) && psel && penable;
  assign pready  = access;
  assign wr_en   = access && pwrite;
  assign rd_en   = access && !pwrite;
  assign pslverr = wr_en && (paddr == ADDR_DR) && status.tip;
  assign dr_wr   = wr_en && (paddr == ADDR_DR) && !status.tip;

  always_ff @(posedge PClk) begin
    if (!PRESETn) begin
      cr1 <= CR1_RESET;
      cr2 <= CR2_RESET;
      br  <= BR_RESET;
    end else if (wr_en) begin
      case (paddr)
        ADDR_CR1: cr1 <= pwdata;
        ADDR_CR2: cr2 <= pwdata & CR2_MASK;
        ADDR_BR:  br  <= pwdata & BR_MASK;
        default:  ;
      endcase
    end
  end

  // a new tx byte wins over rx capture and start sends dr in the next cycle
  always_ff @(posedge PClk) begin
    if (!PRESETn) begin
      dr    <= '0;
      spif  <= 1'b0;
      start <= 1'b0;
    end else begin
      if (dr_wr) begin
        dr <= pwdata;
      end else if (status.done) begin
        dr <= status.rx_data;
      end
      if (status.done) begin
        spif <= 1'b1;
      end else if (rd_en && (paddr == ADDR_DR)) begin
        spif <= 1'b0;
      end
      start <= dr_wr && cr1[CR1_SPE] && cr1[CR1_MSTR] && (mode == SPI_RUN);
    end
  end

  assign cfg.cpol  = cr1[CR1_CPOL];
  assign cfg.cpha  = cr1[CR1_CPHA];
  assign cfg.lsbfe = cr1[CR1_LSBFE];
  assign cfg.ssoe  = cr1[CR1_SSOE];
  assign cfg.sppr  = br[BR_SPPR_LSB +: 3];
  assign cfg.spr   = br[BR_SPR_LSB +: 3];
  assign tx_data   = dr;

  assign sptef = !status.tip && !start;
  assign modf  = !ss_in && cr1[CR1_MSTR] && cr2[CR2_MODFEN] && !cr1[CR1_SSOE];

  always_comb begin
    sr = '0;
    sr[SR_SPIF]  = spif;
    sr[SR_SPTEF] = sptef;
    sr[SR_MODF]  = modf;
  end

  always_comb begin
    prdata = '0;
    if (rd_en) begin
      case (paddr)
        ADDR_CR1: prdata = cr1;
        ADDR_CR2: prdata = cr2;
        ADDR_BR:  prdata = br;
        ADDR_SR:  prdata = sr;
        ADDR_DR:  prdata = dr;
        default:  prdata = '0;
      endcase
    end
  end

  always_ff @(posedge PClk) begin
    if (!PRESETn) begin
      mode <= SPI_RUN;
    end else begin
      mode <= mode_nxt;
    end
  end

  always_comb begin
    mode_nxt = mode;
    case (mode)
      SPI_RUN: begin
        if (!cr1[CR1_SPE]) mode_nxt = SPI_WAIT;
      end
      SPI_WAIT: begin
        if (cr1[CR1_SPE]) begin
          mode_nxt = SPI_RUN;
        end else if (cr2[CR2_SPISWAI]) begin
          mode_nxt = SPI_STOP;
        end
      end
      SPI_STOP: begin
        if (!cr2[CR2_SPISWAI]) begin
          mode_nxt = SPI_WAIT;
        end else if (cr1[CR1_SPE]) begin
          mode_nxt = SPI_RUN;
        end
      end
      default: mode_nxt = SPI_RUN;
    endcase
  end

  // transfers pause outside run
  assign baud_run = (mode == SPI_RUN);
  assign irq = (cr1[CR1_SPIE] && spif) || (cr1[CR1_SPTIE] && sptef);

  // a DR write during a transfer must never restart the shifter
  a_start_idle: assert property (@(posedge PClk) disable iff (!PRESETn)
    start |-> !status.tip);

  // every ENABLE phase completes at once, so an error response always comes with ready
  a_enable_ready: assert property (@(posedge PClk) disable iff (!PRESETn)
    (psel && penable) |-> pready);

endmodule

// File: src/spi_baud_gen.sv
`timescale 1ns/1ns

module spi_baud_gen
  import spi_xfer_pkg::*;
(
  input  logic     PClk,
  input  logic     PRESETn,
  input  spi_cfg_t cfg,
  input  logic     run,
  input  logic     clear,
  output logic     tick
);

  spi_count_t div;
  spi_count_t cnt;

  // half-period of sck in PClk cycles
  assign div = (spi_count_t'(cfg.sppr) + spi_count_t'(1)) << cfg.spr;

  always_ff @(posedge PClk) begin
    if (!PRESETn) begin
      cnt <= '0;
    end else if (clear) begin
      cnt <= div - spi_count_t'(1);
    end else if (run) begin
      if (cnt == '0) begin
        cnt <= div - spi_count_t'(1);
      end else begin
        cnt <= cnt - spi_count_t'(1);
      end
    end
  end

  assign tick = run && !clear && (cnt == '0);

  a_tick_spacing: assert property (@(posedge PClk) disable iff (!PRESETn)
    (tick && (div != spi_count_t'(1))) |=> !tick);

endmodule

// File: src/spi_shifter.sv
`timescale 1ns/1ns

module spi_shifter
  import spi_xfer_pkg::*;
(
  input  logic        PClk,
  input  logic        PRESETn,
  input  spi_cfg_t    cfg,
  input  logic        start,
  input  spi_byte_t   tx_data,
  input  logic        tick,
  input  logic        miso,
  output spi_status_t status,
  output logic        baud_clear,
  output logic        sck,
  output logic        mosi,
  output logic        ss_n
);

  logic      tip;
  logic      done;
  spi_edge_t edge_cnt;
  spi_byte_t tx_sr;
  spi_byte_t rx_sr;
  logic      sample_edge;
  logic      last_edge;

  // even edges lead, odd edges trail
  assign sample_edge = (edge_cnt[0] == cfg.cpha);
  assign last_edge   = (edge_cnt == LAST_EDGE);

  always_ff @(posedge PClk) begin
    if (!PRESETn) begin
      tip      <= 1'b0;
      done     <= 1'b0;
      edge_cnt <= '0;
      sck      <= cfg.cpol;
      ss_n     <= 1'b1;
    end else begin
      done <= 1'b0;
      if (start) begin
        tip      <= 1'b1;
        edge_cnt <= '0;
        sck      <= cfg.cpol;
        ss_n     <= !cfg.ssoe;
      end else if (tip) begin
        if (tick) begin
          sck      <= !sck;
          edge_cnt <= edge_cnt + spi_edge_t'(1);
          if (last_edge) begin
            tip  <= 1'b0;
            done <= 1'b1;
            ss_n <= 1'b1;
          end
        end
      end else begin
        sck  <= cfg.cpol;
        ss_n <= 1'b1;
      end
    end
  end

  // first bit is already on mosi at start, so edge 0 never shifts
  always_ff @(posedge PClk) begin
    if (start) begin
      tx_sr <= tx_data;
    end else if (tip && tick && !sample_edge && (edge_cnt != '0)) begin
      if (cfg.lsbfe) begin
        tx_sr <= {1'b0, tx_sr[7:1]};
      end else begin
        tx_sr <= {tx_sr[6:0], 1'b0};
      end
    end
  end

  always_ff @(posedge PClk) begin
    if (tip && tick && sample_edge) begin
      if (cfg.lsbfe) begin
        rx_sr <= {miso, rx_sr[7:1]};
      end else begin
        rx_sr <= {rx_sr[6:0], miso};
      end
    end
  end

  assign mosi = cfg.lsbfe ? tx_sr[0] : tx_sr[7];

  assign baud_clear     = !tip;
  assign status.tip     = tip;
  assign status.done    = done;
  assign status.rx_data = rx_sr;

  a_ss_idle: assert property (@(posedge PClk) disable iff (!PRESETn)
    !tip |-> ss_n);

endmodule

// File: src/spi_apb_top.sv
`timescale 1ns/1ns

module spi_apb_top
  import spi_reg_pkg::*;
  import spi_xfer_pkg::*;
(
  input  logic      PClk,
  input  logic      PRESETn,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  reg_addr_t paddr,
  input  spi_byte_t pwdata,
  output spi_byte_t prdata,
  output logic      pready,
  output logic      pslverr,
  input  logic      ss_in,
  input  logic      miso,
  output logic      sck,
  output logic      mosi,
  output logic      ss_n,
  output logic      irq,
  output spi_mode_e mode
);

  spi_cfg_t    cfg;
  spi_status_t status;
  spi_byte_t   tx_data;
  logic        start;
  logic        baud_run;
  logic        baud_clear;
  logic        tick;

  spi_apb_regs u_spi_apb_regs (
    .PClk     (PClk),
    .PRESETn  (PRESETn),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .ss_in    (ss_in),
    .status   (status),
    .cfg      (cfg),
    .start    (start),
    .tx_data  (tx_data),
    .baud_run (baud_run),
    .mode     (mode),
    .irq      (irq)
  );

  spi_baud_gen u_spi_baud_gen (
    .PClk    (PClk),
    .PRESETn (PRESETn),
    .cfg     (cfg),
    .run     (baud_run),
    .clear   (baud_clear),
    .tick    (tick)
  );

  spi_shifter u_spi_shifter (
    .PClk       (PClk),
    .PRESETn    (PRESETn),
    .cfg        (cfg),
    .start      (start),
    .tx_data    (tx_data),
    .tick       (tick),
    .miso       (miso),
    .status     (status),
    .baud_clear (baud_clear),
    .sck        (sck),
    .mosi       (mosi),
    .ss_n       (ss_n)
  );

endmodule

// File: verification/spi_slave_bfm.sv
`timescale 1ns/1ns

module spi_slave_bfm
  import spi_xfer_pkg::*;
(
  input  logic      sck,
  input  logic      mosi,
  input  logic      arm,
  input  logic      cpol,
  input  logic      cpha,
  input  logic      lsbfe,
  input  spi_byte_t reply,
  output logic      miso,
  output spi_byte_t captured
);

  spi_byte_t out_sr;
  logic      leading;
  int        edge_idx;

  initial begin
    miso     = 1'b0;
    captured = '0;
    out_sr   = '0;
    leading  = 1'b0;
    forever begin
      @(posedge arm);
      out_sr   = reply;
      captured = '0;
      // first bit goes out before any sck edge
      miso     = lsbfe ? reply[0] : reply[7];
      for (edge_idx = 0; edge_idx < 16; edge_idx++) begin
        @(sck);
        leading = (sck != cpol);
        if (leading ^ cpha) begin
          if (lsbfe) begin
            captured = {mosi, captured[7:1]};
          end else begin
            captured = {captured[6:0], mosi};
          end
        end else if (edge_idx != 0) begin
          if (lsbfe) begin
            out_sr = {1'b0, out_sr[7:1]};
            miso   = out_sr[0];
          end else begin
            out_sr = {out_sr[6:0], 1'b0};
            miso   = out_sr[7];
          end
        end
      end
    end
  end

endmodule

// File: verification/spi_apb_tb.sv
`timescale 1ns/1ns

module spi_apb_tb
  import spi_reg_pkg::*;
  import spi_xfer_pkg::*;
();

  localparam int CLK_PERIOD  = 4;
  localparam int N_REG       = 8;
  localparam int N_XFER      = 12;
  // (7+1) << 2 with spr limited to 2
  localparam int MAX_DIV     = 32;
  localparam int XFER_CYCLES = 16 * MAX_DIV + 64;
  localparam int REG_CYCLES  = 10 + 24 * N_REG + 150;
  localparam int MAX_POLLS   = XFER_CYCLES;
  localparam int WATCHDOG_NS = 2 * ((N_XFER + 1) * XFER_CYCLES + REG_CYCLES) * CLK_PERIOD;

  logic      PClk = 1'b0;
  logic      PRESETn;
  logic      psel;
  logic      penable;
  logic      pwrite;
  reg_addr_t paddr;
  spi_byte_t pwdata;
  spi_byte_t prdata;
  logic      pready;
  logic      pslverr;
  logic      ss_in;
  logic      miso;
  logic      sck;
  logic      mosi;
  logic      ss_n;
  logic      irq;
  spi_mode_e mode;

  logic        arm;
  logic        bfm_cpol;
  logic        bfm_cpha;
  logic        bfm_lsbfe;
  spi_byte_t   bfm_reply;
  spi_byte_t   bfm_captured;
  logic        ss_low_seen;
  logic [31:0] lcg_state;
  spi_byte_t   m_cr1;
  spi_byte_t   m_cr2;
  spi_byte_t   m_br;
  int          errors;
  int          checks;
  int          tests;

  always #(CLK_PERIOD / 2) PClk = ~PClk;

  spi_apb_top u_spi_apb_top (
    .PClk    (PClk),
    .PRESETn (PRESETn),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .ss_in   (ss_in),
    .miso    (miso),
    .sck     (sck),
    .mosi    (mosi),
    .ss_n    (ss_n),
    .irq     (irq),
    .mode    (mode)
  );

  spi_slave_bfm u_spi_slave_bfm (
    .sck      (sck),
    .mosi     (mosi),
    .arm      (arm),
    .cpol     (bfm_cpol),
    .cpha     (bfm_cpha),
    .lsbfe    (bfm_lsbfe),
    .reply    (bfm_reply),
    .miso     (miso),
    .captured (bfm_captured)
  );

  // slave select history of the armed transfer
  always @(posedge PClk) begin
    if (!arm) begin
      ss_low_seen <= 1'b0;
    end else if (!ss_n) begin
      ss_low_seen <= 1'b1;
    end
  end

  function automatic spi_byte_t rand_byte();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:24];
  endfunction

  task automatic check_byte(input string name, input spi_byte_t exp, input spi_byte_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: expected 0x%02h, actual 0x%02h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_mode(input string name, input spi_mode_e exp, input spi_mode_e act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: expected %s, actual %s", name, exp.name(), act.name());
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests++;
    if (errors == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d error(s)", name, errors - errors_before);
    end
  endtask

  task automatic apb_write(input reg_addr_t addr, input spi_byte_t data, output logic err);
    @(negedge PClk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge PClk);
    penable = 1'b1;
    #1;
    err = pslverr;
    if (pready !== 1'b1) begin
      errors++;
      $display("APB write to address %0d saw no PREADY in the ENABLE cycle", addr);
    end
    @(negedge PClk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input reg_addr_t addr, output spi_byte_t data, output logic err);
    @(negedge PClk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge PClk);
    penable = 1'b1;
    #1;
    data = prdata;
    err  = pslverr;
    if (pready !== 1'b1) begin
      errors++;
      $display("APB read from address %0d saw no PREADY in the ENABLE cycle", addr);
    end
    @(negedge PClk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic wait_spif(input string name);
    spi_byte_t sr;
    logic      err;
    int        polls;
    sr    = '0;
    polls = 0;
    while (!sr[SR_SPIF] && polls < MAX_POLLS) begin
      apb_read(ADDR_SR, sr, err);
      polls++;
    end
    if (!sr[SR_SPIF]) begin
      errors++;
      $display("%s: SPIF did not set within %0d status reads", name, MAX_POLLS);
    end
  endtask

  task automatic test_reset_values();
    int        e0;
    spi_byte_t rd;
    logic      err;
    e0 = errors;
    repeat (10) @(negedge PClk);
    check_mode("reset mode", SPI_RUN, mode);
    check_bit("reset irq", 1'b0, irq);
    check_bit("reset ss_n", 1'b1, ss_n);
    check_bit("reset sck", 1'b0, sck);
    check_bit("reset pready", 1'b0, pready);
    check_bit("reset pslverr", 1'b0, pslverr);
    PRESETn = 1'b1;
    apb_read(ADDR_CR1, rd, err);
    check_byte("reset CR1", 8'h04, rd);
    apb_read(ADDR_CR2, rd, err);
    check_byte("reset CR2", 8'h00, rd);
    apb_read(ADDR_BR, rd, err);
    check_byte("reset BR", 8'h00, rd);
    apb_read(ADDR_SR, rd, err);
    check_byte("reset SR", 8'h20, rd);
    apb_read(ADDR_DR, rd, err);
    check_byte("reset DR", 8'h00, rd);
    report_test("reset_values", e0);
  endtask

  task automatic test_registers();
    int        e0;
    spi_byte_t v;
    spi_byte_t rd;
    logic      err;
    e0 = errors;
    for (int i = 0; i < N_REG; i++) begin
      v = rand_byte();
      apb_write(ADDR_CR1, v, err);
      m_cr1 = v;
      v = rand_byte();
      apb_write(ADDR_CR2, v, err);
      m_cr2 = v & CR2_MASK;
      v = rand_byte();
      apb_write(ADDR_BR, v, err);
      m_br = v & BR_MASK;
      apb_read(ADDR_CR1, rd, err);
      check_byte($sformatf("registers CR1 #%0d", i), m_cr1, rd);
      apb_read(ADDR_CR2, rd, err);
      check_byte($sformatf("registers CR2 #%0d", i), m_cr2, rd);
      apb_read(ADDR_BR, rd, err);
      check_byte($sformatf("registers BR #%0d", i), m_br, rd);
    end
    for (int a = 4; a < 8; a++) begin
      if (a != 5) begin
        apb_write(reg_addr_t'(a), rand_byte(), err);
        check_bit($sformatf("registers write %0d PSLVERR", a), 1'b0, err);
        apb_read(reg_addr_t'(a), rd, err);
        check_byte($sformatf("registers read %0d", a), 8'h00, rd);
        check_bit($sformatf("registers read %0d PSLVERR", a), 1'b0, err);
      end
    end
    // SR is read-only and ss_in high keeps MODF clear
    apb_write(ADDR_SR, rand_byte(), err);
    apb_read(ADDR_SR, rd, err);
    check_byte("registers SR write ignored", 8'h20, rd);
    report_test("registers", e0);
  endtask

  task automatic run_transfer(input string name, input spi_byte_t cr1, input spi_byte_t br,
                              input spi_byte_t tx, input spi_byte_t reply, input logic busy);
    spi_byte_t rd;
    logic      err;
    int        polls;
    apb_write(ADDR_CR2, 8'h00, err);
    apb_write(ADDR_BR, br, err);
    apb_write(ADDR_CR1, cr1, err);
    repeat (2) @(negedge PClk);
    check_bit($sformatf("%s sck idle level", name), cr1[CR1_CPOL], sck);
    bfm_cpol  = cr1[CR1_CPOL];
    bfm_cpha  = cr1[CR1_CPHA];
    bfm_lsbfe = cr1[CR1_LSBFE];
    bfm_reply = reply;
    arm       = 1'b1;
    apb_write(ADDR_DR, tx, err);
    check_bit($sformatf("%s DR write PSLVERR", name), 1'b0, err);
    if (busy) begin
      rd    = 8'hFF;
      polls = 0;
      while (rd[SR_SPTEF] && polls < 8) begin
        apb_read(ADDR_SR, rd, err);
        polls++;
      end
      check_bit($sformatf("%s SPTEF low", name), 1'b0, rd[SR_SPTEF]);
      apb_write(ADDR_DR, ~tx, err);
      check_bit($sformatf("%s busy DR write PSLVERR", name), 1'b1, err);
    end
    wait_spif(name);
    @(negedge PClk);
    // SPIF and SPTEF are both set once the byte is done
    check_bit($sformatf("%s irq", name), cr1[CR1_SPIE] | cr1[CR1_SPTIE], irq);
    check_byte($sformatf("%s MOSI byte", name), tx, bfm_captured);
    check_bit($sformatf("%s ss_n low seen", name), cr1[CR1_SSOE], ss_low_seen);
    apb_read(ADDR_DR, rd, err);
    check_byte($sformatf("%s DR read", name), reply, rd);
    apb_read(ADDR_SR, rd, err);
    check_byte($sformatf("%s SR after DR read", name), 8'h20, rd);
    check_bit($sformatf("%s irq after DR read", name), cr1[CR1_SPTIE], irq);
    @(negedge PClk);
    arm = 1'b0;
  endtask

  task automatic test_transfers();
    int        e0;
    spi_byte_t r;
    spi_byte_t cr1;
    spi_byte_t br;
    e0 = errors;
    for (int i = 0; i < N_XFER; i++) begin
      // random SPIE, SPTIE, CPOL, CPHA, SSOE, LSBFE with SPE and MSTR set
      r   = rand_byte();
      cr1 = (r & 8'hAF) | 8'h50;
      r   = rand_byte();
      br  = {1'b0, r[6:4], 2'b00, r[1:0] % 2'd3};
      run_transfer($sformatf("transfer #%0d", i), cr1, br, rand_byte(), rand_byte(), 1'b0);
    end
    report_test("transfers", e0);
  endtask

  task automatic test_busy_write();
    int e0;
    e0 = errors;
    // divisor 8 keeps the byte busy long enough for the second write
    run_transfer("busy_write", 8'h52, 8'h12, rand_byte(), rand_byte(), 1'b1);
    report_test("busy_write", e0);
  endtask

  task automatic test_modes();
    int   e0;
    logic err;
    e0 = errors;
    apb_write(ADDR_CR2, 8'h00, err);
    apb_write(ADDR_CR1, 8'h10, err);
    repeat (2) @(negedge PClk);
    check_mode("modes SPE clear", SPI_WAIT, mode);
    apb_write(ADDR_CR2, 8'h02, err);
    repeat (2) @(negedge PClk);
    check_mode("modes SPISWAI set", SPI_STOP, mode);
    apb_write(ADDR_CR1, 8'h50, err);
    repeat (2) @(negedge PClk);
    check_mode("modes SPE set", SPI_RUN, mode);
    apb_write(ADDR_CR2, 8'h00, err);
    report_test("modes", e0);
  endtask

  task automatic test_modf();
    int        e0;
    spi_byte_t rd;
    logic      err;
    e0 = errors;
    apb_write(ADDR_CR2, 8'h10, err);
    apb_write(ADDR_CR1, 8'h10, err);
    @(negedge PClk);
    ss_in = 1'b0;
    apb_read(ADDR_SR, rd, err);
    check_bit("modf ss_in low", 1'b1, rd[SR_MODF]);
    @(negedge PClk);
    ss_in = 1'b1;
    apb_read(ADDR_SR, rd, err);
    check_bit("modf ss_in high", 1'b0, rd[SR_MODF]);
    report_test("modf", e0);
  endtask

  initial begin
    PRESETn   = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    ss_in     = 1'b1;
    arm       = 1'b0;
    bfm_cpol  = 1'b0;
    bfm_cpha  = 1'b0;
    bfm_lsbfe = 1'b0;
    bfm_reply = '0;
    m_cr1     = '0;
    m_cr2     = '0;
    m_br      = '0;
    lcg_state = 32'd48577;
    errors    = 0;
    checks    = 0;
    tests     = 0;
    test_reset_values();
    test_registers();
    test_transfers();
    test_busy_write();
    test_modes();
    test_modf();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
    $display("Regression failed");
    $finish;
  end

endmodule

// File: spi_apb.f
src/spi_reg_pkg.sv
src/spi_xfer_pkg.sv
src/spi_apb_regs.sv
src/spi_baud_gen.sv
src/spi_shifter.sv
src/spi_apb_top.sv
verification/spi_slave_bfm.sv
verification/spi_apb_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= spi_apb_tb
FILELIST  ?= spi_apb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0 --assert --timescale 1ns/1ns
PASS_MSG  ?= Regression passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
